/* sources.f */
design/datapath_pkg.sv
design/isa_pkg.sv
design/gpr_cell.sv
design/select_and_encode.sv
design/bus_mux.sv
design/alu.sv
design/datapath_regs.sv
design/main_memory.sv
design/datapath_top.sv
testbench/tb_clock_gen.sv
testbench/datapath_assert.sv
testbench/datapath_tb.sv

/* testbench/datapath_tb.sv */
`timescale 1ns/1ps

module datapath_tb
    import datapath_pkg::*;
    import isa_pkg::*;
();

    // the sequence runs well under this
    localparam int max_cycles = 4000;

    logic                  clk;
    logic                  reset;
    logic [data_width-1:0] in_port_data;
    alu_op_t               opcode;
    logic pc_out, zhigh_out, zlow_out, hi_out, lo_out, in_port_out, mdr_out, c_out;
    logic mdr_enable, mar_enable, z_enable, y_enable, pc_enable, lo_enable, hi_enable;
    logic ir_enable, out_port_enable, inc_pc, read, ram_write_enable, con_in;
    logic gra, grb, grc, r_in, r_out, ba_out;
    logic [data_width-1:0] bus_value;
    logic [data_width-1:0] out_port_data;
    logic                  con_flag;

    // pending expectations for the compare process
    logic [data_width-1:0] exp_bus, exp_port, exp_high, exp_low, captured_low;
    logic exp_flag, bus_check, port_check, flag_check, zlow_check, zhigh_check;

    logic [data_width-1:0] shadow [num_gprs];
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_start_errors = 0;

    tb_clock_gen u_clock (.clk(clk), .reset(reset));

    datapath_top DUT (.*);

    function automatic logic [2*data_width-1:0] model_alu(input alu_op_t op,
            input logic [data_width-1:0] a, input logic [data_width-1:0] b);
        logic [4:0]                   n;
        logic [2*data_width-1:0]      wide;
        logic signed [data_width-1:0] q;
        n = b[4:0];
        wide = '0;
        case (op)
            op_add:  wide[31:0] = a + b;
            op_sub:  wide[31:0] = a - b;
            op_and:  wide[31:0] = a & b;
            op_or:   wide[31:0] = a | b;
            op_shr:  wide[31:0] = a >> n;
            op_shra: wide[31:0] = 32'({{32{a[31]}}, a} >> n);
            op_shl:  wide[31:0] = a << n;
            op_ror:  wide[31:0] = (a >> n) | (a << (32 - n));
            op_rol:  wide[31:0] = (a << n) | (a >> (32 - n));
            op_mul:  wide = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            op_div: begin
                if (b != '0) begin
                    q = $signed(a) / $signed(b);
                    wide = {a - q * b, q};
                end
            end
            op_neg:  wide[31:0] = 32'd0 - b;
            op_not:  wide[31:0] = ~b;
            default: wide = '0;
        endcase
        return wide;
    endfunction

    function automatic logic con_rule(input logic [cond_width-1:0] cond,
            input logic [data_width-1:0] value);
        case (cond)
            cond_zero:     return value == '0;
            cond_nonzero:  return value != '0;
            cond_positive: return value[31] == 1'b0 && value != '0;
            default:       return value[31];
        endcase
    endfunction

    function automatic logic [data_width-1:0] reg_word(input logic [3:0] ra,
            input logic [3:0] rb, input logic [3:0] rc);
        instr_t w;
        w = '0;
        w.reg_view.ra = ra;
        w.reg_view.rb = rb;
        w.reg_view.rc = rc;
        return w;
    endfunction

    task automatic check_word(input string name, input logic [data_width-1:0] expected,
            input logic [data_width-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_result(input logic [data_width-1:0] expected_high,
            input logic [data_width-1:0] expected_low, input logic [data_width-1:0] high,
            input logic [data_width-1:0] low);
        check_count++;
        if (high !== expected_high || low !== expected_low) begin
            error_count++;
            $display("FAILED at %0t: z expected %h_%h got %h_%h", $time,
                     expected_high, expected_low, high, low);
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (bus_check) check_word("bus_value", exp_bus, bus_value);
        if (port_check) check_word("out_port_data", exp_port, out_port_data);
        if (flag_check) check_flag("con_flag", exp_flag, con_flag);
        if (zlow_check) captured_low = bus_value;
        if (zhigh_check) check_result(exp_high, exp_low, bus_value, captured_low);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: test sequence still running after %0d cycles", max_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic clear_inputs();
        {pc_out, zhigh_out, zlow_out, hi_out, lo_out, in_port_out, mdr_out, c_out} <= '0;
        {mdr_enable, mar_enable, z_enable, y_enable, pc_enable, lo_enable, hi_enable} <= '0;
        {ir_enable, out_port_enable, inc_pc, read, ram_write_enable, con_in} <= '0;
        {gra, grb, grc, r_in, r_out, ba_out} <= '0;
        {bus_check, port_check, flag_check, zlow_check, zhigh_check} <= '0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        clear_inputs();
    endtask

    task automatic expect_bus(input logic [data_width-1:0] word);
        exp_bus <= word;
        bus_check <= 1'b1;
    endtask

    // word enters through the input port, which lags one cycle
    task automatic bus_word(input logic [data_width-1:0] word);
        next_cycle();
        in_port_data <= word;
        next_cycle();
        in_port_out <= 1'b1;
    endtask

    task automatic set_ir(input logic [data_width-1:0] word);
        bus_word(word);
        ir_enable <= 1'b1;
    endtask

    task automatic write_gpr(input logic [3:0] k, input logic [data_width-1:0] word);
        set_ir(reg_word(k, k, k));
        bus_word(word);
        r_in <= 1'b1;
        gra <= 1'b1;
        shadow[k] = word;
    endtask

    task automatic read_gpr(input int sel, input logic [data_width-1:0] expected);
        next_cycle();
        r_out <= 1'b1;
        gra <= (sel == 0);
        grb <= (sel == 1);
        grc <= (sel == 2);
        expect_bus(expected);
    endtask

    task automatic run_alu(input alu_op_t op, input logic [data_width-1:0] a,
            input logic [data_width-1:0] b);
        logic [2*data_width-1:0] expected;
        expected = model_alu(op, a, b);
        bus_word(a);
        y_enable <= 1'b1;
        bus_word(b);
        z_enable <= 1'b1;
        opcode <= op;
        next_cycle();
        zlow_out <= 1'b1;
        zlow_check <= 1'b1;
        next_cycle();
        zhigh_out <= 1'b1;
        zhigh_check <= 1'b1;
        exp_high <= expected[63:32];
        exp_low <= expected[31:0];
    endtask

    // one more edge lets the last check land
    task automatic end_test(input string name);
        next_cycle();
        tests_run++;
        if (error_count != test_start_errors) begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name,
                     error_count - test_start_errors);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        test_start_errors = error_count;
    endtask

    initial begin
        logic [data_width-1:0] a, b, v, w, addr, p;
        logic [3:0]            ra, rb, rc;
        instr_t                br;
        int                    n, total_errors;
        void'($urandom(6654));
        clear_inputs();
        in_port_data <= '0;
        opcode <= op_add;
        for (int k = 0; k < num_gprs; k++) shadow[k] = '0;
        wait (reset == 1'b0);

        next_cycle();
        expect_bus('0);
        exp_port <= '0;
        port_check <= 1'b1;
        exp_flag <= 1'b0;
        flag_check <= 1'b1;
        for (int k = 0; k < num_gprs; k++) begin
            set_ir(reg_word(4'(k), 4'(k), 4'(k)));
            read_gpr(k % 3, '0);
        end
        end_test("reset values");

        write_gpr(4'd0, $urandom() | 32'd1);
        for (int i = 0; i < 12; i++) write_gpr(4'($urandom_range(15)), $urandom());
        for (int i = 0; i < 8; i++) begin
            ra = 4'($urandom_range(15));
            rb = 4'($urandom_range(15));
            rc = 4'($urandom_range(15));
            set_ir(reg_word(ra, rb, rc));
            read_gpr(0, shadow[ra]);
            read_gpr(1, shadow[rb]);
            read_gpr(2, shadow[rc]);
        end
        // r0 under ba_out is a zero base, other registers read normally
        set_ir(reg_word(4'd0, 4'd5, 4'd0));
        read_gpr(0, '0);
        ba_out <= 1'b1;
        read_gpr(1, shadow[5]);
        ba_out <= 1'b1;
        end_test("register moves");

        for (int i = 0; i <= int'(op_not); i++) begin
            for (int rep = 0; rep < 2; rep++) begin
                a = $urandom();
                b = $urandom();
                if (b == '0) b = 32'd7;
                run_alu(alu_op_t'(i), a, b);
            end
        end
        end_test("alu through z");

        for (int i = 0; i < 4; i++) begin
            w = $urandom();
            w[18] = (i % 2 == 0);
            set_ir(w);
            next_cycle();
            c_out <= 1'b1;
            expect_bus((w & 32'h0007_ffff) | ((i % 2 == 0) ? 32'hfff8_0000 : 32'h0));
        end
        end_test("sign-extended constant");

        for (int i = 0; i < 3; i++) begin
            addr = 32'($urandom_range(511));
            v = $urandom();
            bus_word(addr);
            mar_enable <= 1'b1;
            bus_word(v);
            mdr_enable <= 1'b1;
            next_cycle();
            ram_write_enable <= 1'b1;
            bus_word(~v);
            mdr_enable <= 1'b1;
            // same low nine bits behind different upper bits
            bus_word(addr | ($urandom() << 9));
            mar_enable <= 1'b1;
            next_cycle();
            read <= 1'b1;
            mdr_enable <= 1'b1;
            next_cycle();
            mdr_out <= 1'b1;
            out_port_enable <= 1'b1;
            expect_bus(v);
            next_cycle();
            exp_port <= v;
            port_check <= 1'b1;
        end
        end_test("memory and output port");

        for (int c = 0; c < 4; c++) begin
            for (int j = 0; j < 3; j++) begin
                if (j == 0) v = '0;
                else if (j == 1) v = {1'b0, 31'($urandom())} | 32'd1;
                else v = {1'b1, 31'($urandom())};
                br = '0;
                br.branch_view.cond = 2'(c);
                set_ir(br);
                bus_word(v);
                con_in <= 1'b1;
                next_cycle();
                exp_flag <= con_rule(2'(c), v);
                flag_check <= 1'b1;
            end
        end
        p = $urandom();
        bus_word(p);
        pc_enable <= 1'b1;
        n = $urandom_range(9, 3);
        for (int i = 0; i < n; i++) begin
            next_cycle();
            inc_pc <= 1'b1;
        end
        next_cycle();
        pc_out <= 1'b1;
        expect_bus(p + 32'(n));
        bus_word(~p);
        pc_enable <= 1'b1;
        inc_pc <= 1'b1;
        next_cycle();
        pc_out <= 1'b1;
        expect_bus(~p);
        end_test("condition flag and pc");

        total_errors = error_count + DUT.u_assert.assert_failures;
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, check_count, error_count,
                 DUT.u_assert.assert_failures);
        if (total_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* testbench/datapath_assert.sv */
`timescale 1ns/1ps

module datapath_assert
    import datapath_pkg::*;
(
    input logic                  clk,
    input logic                  reset,
    input logic [data_width-1:0] bus_value,
    input logic                  pc_out,
    input logic                  zhigh_out,
    input logic                  zlow_out,
    input logic                  hi_out,
    input logic                  lo_out,
    input logic                  in_port_out,
    input logic                  mdr_out,
    input logic                  c_out,
    input logic                  r_out,
    input logic                  out_port_enable,
    input logic [data_width-1:0] out_port_data,
    input logic                  con_in,
    input logic                  con_flag
);

    int   assert_failures = 0;
    logic any_source;

    assign any_source = pc_out || zhigh_out || zlow_out || hi_out || lo_out
                     || in_port_out || mdr_out || c_out || r_out;

    // idle bus reads as zero
    idle_bus_zero: assert property (@(posedge clk) disable iff (reset)
        !any_source |-> bus_value == '0)
        else begin
            assert_failures++;
            $error("bus not zero with no source enabled");
        end

    port_needs_enable: assert property (@(posedge clk) disable iff (reset)
        $changed(out_port_data) |-> $past(out_port_enable))
        else begin
            assert_failures++;
            $error("out_port_data changed without out_port_enable");
        end

    flag_needs_con_in: assert property (@(posedge clk) disable iff (reset)
        $changed(con_flag) |-> $past(con_in))
        else begin
            assert_failures++;
            $error("con_flag changed without con_in");
        end

endmodule

bind datapath_top datapath_assert u_assert (.*);

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // released on a rising edge like every other stimulus
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* design/datapath_top.sv */
`timescale 1ns/1ps

module datapath_top
    import datapath_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [data_width-1:0] in_port_data,
    input  alu_op_t               opcode,
    input  logic                  pc_out,
    input  logic                  zhigh_out,
    input  logic                  zlow_out,
    input  logic                  hi_out,
    input  logic                  lo_out,
    input  logic                  in_port_out,
    input  logic                  mdr_out,
    input  logic                  c_out,
    input  logic                  mdr_enable,
    input  logic                  mar_enable,
    input  logic                  z_enable,
    input  logic                  y_enable,
    input  logic                  pc_enable,
    input  logic                  lo_enable,
    input  logic                  hi_enable,
    input  logic                  ir_enable,
    input  logic                  out_port_enable,
    input  logic                  inc_pc,
    input  logic                  read,
    input  logic                  ram_write_enable,
    input  logic                  con_in,
    input  logic                  gra,
    input  logic                  grb,
    input  logic                  grc,
    input  logic                  r_in,
    input  logic                  r_out,
    input  logic                  ba_out,
    output logic [data_width-1:0] bus_value,
    output logic [data_width-1:0] out_port_data,
    output logic                  con_flag
);

    logic [data_width-1:0]      ir;
    logic [reg_index_width-1:0] reg_index;
    logic                       write_strobe;
    logic                       read_strobe;
    logic [data_width-1:0]      c_sign_extended;
    logic [data_width-1:0]      cell_outs [num_gprs];
    logic [data_width-1:0]      alu_high;
    logic [data_width-1:0]      alu_low;
    logic [data_width-1:0]      y_data;
    logic [data_width-1:0]      pc_data;
    logic [data_width-1:0]      zhigh_data;
    logic [data_width-1:0]      zlow_data;
    logic [data_width-1:0]      hi_data;
    logic [data_width-1:0]      lo_data;
    logic [data_width-1:0]      mar_data;
    logic [data_width-1:0]      mdr_data;
    logic [data_width-1:0]      in_port_value;
    logic [data_width-1:0]      mem_data;

    select_and_encode u_select (
        .ir(ir), .gra(gra), .grb(grb), .grc(grc),
        .r_in(r_in), .r_out(r_out), .ba_out(ba_out),
        .reg_index(reg_index), .write_strobe(write_strobe),
        .read_strobe(read_strobe), .c_sign_extended(c_sign_extended)
    );

    // r0 to r15, all sharing one register number
    for (genvar i = 0; i < num_gprs; i++) begin : gen_gpr
        gpr_cell #(.cell_index(i)) u_gpr (
            .clk(clk), .reset(reset), .bus(bus_value),
            .write_index(reg_index), .write_strobe(write_strobe),
            .read_index(reg_index), .read_strobe(read_strobe),
            .cell_out(cell_outs[i])
        );
    end

    bus_mux u_bus_mux (
        .cell_outs(cell_outs), .hi_data(hi_data), .lo_data(lo_data),
        .zhigh_data(zhigh_data), .zlow_data(zlow_data), .pc_data(pc_data),
        .mdr_data(mdr_data), .in_port_value(in_port_value),
        .c_sign_extended(c_sign_extended), .pc_out(pc_out),
        .zhigh_out(zhigh_out), .zlow_out(zlow_out), .hi_out(hi_out),
        .lo_out(lo_out), .in_port_out(in_port_out), .mdr_out(mdr_out),
        .c_out(c_out), .bus(bus_value)
    );

    alu u_alu (
        .a(y_data), .b(bus_value), .opcode(opcode),
        .result_high(alu_high), .result_low(alu_low)
    );

    datapath_regs u_regs (
        .clk(clk), .reset(reset), .bus(bus_value), .alu_high(alu_high),
        .alu_low(alu_low), .mem_data(mem_data), .in_port_data(in_port_data),
        .con_in(con_in), .read(read), .inc_pc(inc_pc),
        .mdr_enable(mdr_enable), .mar_enable(mar_enable), .z_enable(z_enable),
        .y_enable(y_enable), .pc_enable(pc_enable), .lo_enable(lo_enable),
        .hi_enable(hi_enable), .ir_enable(ir_enable),
        .out_port_enable(out_port_enable), .pc_data(pc_data), .ir(ir),
        .y_data(y_data), .zhigh_data(zhigh_data), .zlow_data(zlow_data),
        .hi_data(hi_data), .lo_data(lo_data), .mar_data(mar_data),
        .mdr_data(mdr_data), .in_port_value(in_port_value),
        .out_port_data(out_port_data), .con_flag(con_flag)
    );

    // only the low address bits of MAR reach the memory
    main_memory u_memory (
        .clk(clk), .address(mar_data[mem_addr_width-1:0]),
        .write_data(mdr_data), .write_enable(ram_write_enable),
        .read_data(mem_data)
    );

endmodule

/* design/main_memory.sv */
`timescale 1ns/1ps

module main_memory
    import datapath_pkg::*;
(
    input  logic                      clk,
    input  logic [mem_addr_width-1:0] address,
    input  logic [data_width-1:0]     write_data,
    input  logic                      write_enable,
    output logic [data_width-1:0]     read_data
);

    logic [data_width-1:0] mem [2**mem_addr_width];

    // asynchronous read, MDR captures it on its own edge
    assign read_data = mem[address];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[address] <= write_data;
        end
    end

endmodule

/* design/datapath_regs.sv */
`timescale 1ns/1ps

module datapath_regs
    import datapath_pkg::*;
    import isa_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [data_width-1:0] bus,
    input  logic [data_width-1:0] alu_high,
    input  logic [data_width-1:0] alu_low,
    input  logic [data_width-1:0] mem_data,
    input  logic [data_width-1:0] in_port_data,
    input  logic                  con_in,
    input  logic                  read,
    input  logic                  inc_pc,
    input  logic                  mdr_enable,
    input  logic                  mar_enable,
    input  logic                  z_enable,
    input  logic                  y_enable,
    input  logic                  pc_enable,
    input  logic                  lo_enable,
    input  logic                  hi_enable,
    input  logic                  ir_enable,
    input  logic                  out_port_enable,
    output logic [data_width-1:0] pc_data,
    output logic [data_width-1:0] ir,
    output logic [data_width-1:0] y_data,
    output logic [data_width-1:0] zhigh_data,
    output logic [data_width-1:0] zlow_data,
    output logic [data_width-1:0] hi_data,
    output logic [data_width-1:0] lo_data,
    output logic [data_width-1:0] mar_data,
    output logic [data_width-1:0] mdr_data,
    output logic [data_width-1:0] in_port_value,
    output logic [data_width-1:0] out_port_data,
    output logic                  con_flag
);

    instr_t ir_view;
    logic   con_true;

    assign ir_view = ir;

    // branch condition against the current bus
    always_comb begin
        case (ir_view.branch_view.cond)
            cond_zero:     con_true = (bus == '0);
            cond_nonzero:  con_true = (bus != '0);
            cond_positive: con_true = !bus[data_width-1] && (bus != '0);
            cond_negative: con_true = bus[data_width-1];
            default:       con_true = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_data       <= '0;
            ir            <= '0;
            y_data        <= '0;
            zhigh_data    <= '0;
            zlow_data     <= '0;
            hi_data       <= '0;
            lo_data       <= '0;
            mar_data      <= '0;
            mdr_data      <= '0;
            in_port_value <= '0;
            out_port_data <= '0;
            con_flag      <= 1'b0;
        end else begin
            // input port has no enable
            in_port_value <= in_port_data;
            // a bus load wins over increment
            if (pc_enable) begin
                pc_data <= bus;
            end else if (inc_pc) begin
                pc_data <= pc_data + data_width'(1);
            end
            if (ir_enable) ir <= bus;
            if (y_enable) y_data <= bus;
            if (z_enable) begin
                zhigh_data <= alu_high;
                zlow_data  <= alu_low;
            end
            if (hi_enable) hi_data <= bus;
            if (lo_enable) lo_data <= bus;
            if (mar_enable) mar_data <= bus;
            if (mdr_enable) mdr_data <= read ? mem_data : bus;
            if (out_port_enable) out_port_data <= bus;
            if (con_in) con_flag <= con_true;
        end
    end

endmodule

/* design/alu.sv */
`timescale 1ns/1ps

module alu
    import datapath_pkg::*;
(
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    input  alu_op_t               opcode,
    output logic [data_width-1:0] result_high,
    output logic [data_width-1:0] result_low
);

    logic [shift_width-1:0]         amount;
    logic [2*data_width-1:0]        rot_right;
    logic [2*data_width-1:0]        rot_left;
    logic signed [2*data_width-1:0] product;
    logic signed [data_width-1:0]   quotient;
    logic signed [data_width-1:0]   remainder;

    assign amount = b[shift_width-1:0];

    // rotate by shifting a doubled copy of a
    assign rot_right = {a, a} >> amount;
    assign rot_left  = {a, a} << amount;

    assign product = $signed(a) * $signed(b);

    // divide by zero gives zero in both words
    always_comb begin
        if (b == '0) begin
            quotient  = '0;
            remainder = '0;
        end else begin
            quotient  = $signed(a) / $signed(b);
            remainder = $signed(a) % $signed(b);
        end
    end

    always_comb begin
        result_high = '0;
        result_low  = '0;
        case (opcode)
            op_add:  result_low = a + b;
            op_sub:  result_low = a - b;
            op_and:  result_low = a & b;
            op_or:   result_low = a | b;
            op_shr:  result_low = a >> amount;
            op_shra: result_low = $signed(a) >>> amount;
            op_shl:  result_low = a << amount;
            op_ror:  result_low = rot_right[data_width-1:0];
            op_rol:  result_low = rot_left[2*data_width-1:data_width];
            op_mul: begin
                result_high = product[2*data_width-1:data_width];
                result_low  = product[data_width-1:0];
            end
            op_div: begin
                result_high = remainder;
                result_low  = quotient;
            end
            // unary ops work on the bus operand
            op_neg:  result_low = -b;
            op_not:  result_low = ~b;
            default: result_low = '0;
        endcase
    end

endmodule

/* design/bus_mux.sv */
`timescale 1ns/1ps

module bus_mux
    import datapath_pkg::*;
(
    input  logic [data_width-1:0] cell_outs [num_gprs],
    input  logic [data_width-1:0] hi_data,
    input  logic [data_width-1:0] lo_data,
    input  logic [data_width-1:0] zhigh_data,
    input  logic [data_width-1:0] zlow_data,
    input  logic [data_width-1:0] pc_data,
    input  logic [data_width-1:0] mdr_data,
    input  logic [data_width-1:0] in_port_value,
    input  logic [data_width-1:0] c_sign_extended,
    input  logic                  pc_out,
    input  logic                  zhigh_out,
    input  logic                  zlow_out,
    input  logic                  hi_out,
    input  logic                  lo_out,
    input  logic                  in_port_out,
    input  logic                  mdr_out,
    input  logic                  c_out,
    output logic [data_width-1:0] bus
);

    logic [data_width-1:0] gpr_word;

    // at most one cell is non-zero
    always_comb begin
        gpr_word = '0;
        for (int i = 0; i < num_gprs; i++) begin
            gpr_word |= cell_outs[i];
        end
    end

    // highest priority first, register source last
    always_comb begin
        if (c_out) begin
            bus = c_sign_extended;
        end else if (in_port_out) begin
            bus = in_port_value;
        end else if (mdr_out) begin
            bus = mdr_data;
        end else if (pc_out) begin
            bus = pc_data;
        end else if (zlow_out) begin
            bus = zlow_data;
        end else if (zhigh_out) begin
            bus = zhigh_data;
        end else if (lo_out) begin
            bus = lo_data;
        end else if (hi_out) begin
            bus = hi_data;
        end else begin
            bus = gpr_word;
        end
    end

endmodule

/* design/select_and_encode.sv */
`timescale 1ns/1ps

module select_and_encode
    import datapath_pkg::*;
    import isa_pkg::*;
(
    input  logic [data_width-1:0]      ir,
    input  logic                       gra,
    input  logic                       grb,
    input  logic                       grc,
    input  logic                       r_in,
    input  logic                       r_out,
    input  logic                       ba_out,
    output logic [reg_index_width-1:0] reg_index,
    output logic                       write_strobe,
    output logic                       read_strobe,
    output logic [data_width-1:0]      c_sign_extended
);

    instr_t instr;
    logic   base_is_zero;

    assign instr = ir;

    // gra wins over grb, grb over grc
    always_comb begin
        if (gra) begin
            reg_index = instr.reg_view.ra;
        end else if (grb) begin
            reg_index = instr.reg_view.rb;
        end else if (grc) begin
            reg_index = instr.reg_view.rc;
        end else begin
            reg_index = '0;
        end
    end

    assign write_strobe = r_in;

    // base address rule, r0 reads as zero under ba_out
    assign base_is_zero = ba_out && (reg_index == '0);
    assign read_strobe  = r_out && !base_is_zero;

    assign c_sign_extended = {
        {(data_width - const_width){instr.branch_view.c[const_width-1]}},
        instr.branch_view.c
    };

endmodule

/* design/gpr_cell.sv */
`timescale 1ns/1ps

module gpr_cell
    import datapath_pkg::*;
#(
    parameter int cell_index = 0
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [data_width-1:0]      bus,
    input  logic [reg_index_width-1:0] write_index,
    input  logic                       write_strobe,
    input  logic [reg_index_width-1:0] read_index,
    input  logic                       read_strobe,
    output logic [data_width-1:0]      cell_out
);

    logic [data_width-1:0] value;
    logic                  write_hit;
    logic                  read_hit;

    // each cell decodes its own number
    assign write_hit = write_strobe && (write_index == reg_index_width'(cell_index));
    assign read_hit  = read_strobe && (read_index == reg_index_width'(cell_index));

    always_ff @(posedge clk) begin
        if (reset) begin
            value <= '0;
        end else if (write_hit) begin
            value <= bus;
        end
    end

    // zero when not selected so the bus mux can OR all cells
    assign cell_out = read_hit ? value : '0;

endmodule

/* design/isa_pkg.sv */
package isa_pkg;

    // instruction field widths
    localparam int opcode_width     = 5;
    localparam int reg_field_width  = 4;
    localparam int cond_width       = 2;
    localparam int const_width      = 19;
    localparam int reg_unused_width = 15;
    localparam int branch_pad_width = 2;

    // branch conditions, held in ir[20:19]
    localparam logic [cond_width-1:0] cond_zero     = 2'b00;
    localparam logic [cond_width-1:0] cond_nonzero  = 2'b01;
    localparam logic [cond_width-1:0] cond_positive = 2'b10;
    localparam logic [cond_width-1:0] cond_negative = 2'b11;

    // one instruction word, read as register format or as branch format
    // the constant C is bits 18:0 in either view
    typedef union packed {
        struct packed {
            logic [opcode_width-1:0]     opcode;
            logic [reg_field_width-1:0]  ra;
            logic [reg_field_width-1:0]  rb;
            logic [reg_field_width-1:0]  rc;
            logic [reg_unused_width-1:0] unused;
        } reg_view;
        struct packed {
            logic [opcode_width-1:0]     opcode;
            logic [reg_field_width-1:0]  ra;
            // upper half of the rb slot
            logic [branch_pad_width-1:0] pad;
            logic [cond_width-1:0]       cond;
            logic [const_width-1:0]      c;
        } branch_view;
    } instr_t;

endpackage

/* design/datapath_pkg.sv */
package datapath_pkg;

    // bus, register and memory geometry
    localparam int data_width      = 32;
    localparam int num_gprs        = 16;
    localparam int reg_index_width = 4;
    localparam int mem_addr_width  = 9;

    // shift and rotate amounts come from the low bits of the bus
    localparam int shift_width = 5;

    // alu operations selected by the control unit
    typedef enum logic [4:0] {
        op_add  = 5'd0,
        op_sub  = 5'd1,
        op_and  = 5'd2,
        op_or   = 5'd3,
        op_shr  = 5'd4,
        op_shra = 5'd5,
        op_shl  = 5'd6,
        op_ror  = 5'd7,
        op_rol  = 5'd8,
        op_mul  = 5'd9,
        op_div  = 5'd10,
        op_neg  = 5'd11,
        op_not  = 5'd12
    } alu_op_t;

endpackage
